// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 \
    --top-module conv_engine_tb \
    -f sources.f

./obj_dir/Vconv_engine_tb | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: sources.f
verilog/conv_pkg.sv
verilog/conv_window_if.sv
verilog/conv_cfg_apb.sv
verilog/conv_window.sv
verilog/conv_window_fifo.sv
verilog/conv_mac.sv
verilog/conv_engine_top.sv
tests/conv_engine_chk.sv
tests/conv_engine_tb.sv

// File: tests/conv_engine_chk.sv
`default_nettype none

module conv_engine_chk (
    input wire logic             aclk,
    input wire logic             rst_n,
    input wire logic             psel,
    input wire logic             penable,
    input wire logic             pslverr,
    input wire logic             m_valid,
    input wire conv_pkg::pixel_t m_data,
    input wire logic             m_last,
    input wire logic             m_ready
);

    // a stalled result holds until it is taken
    stall_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
        else $error("result changed while the output was stalled");

    last_needs_valid: assert property (@(posedge aclk) disable iff (!rst_n)
        m_last |-> m_valid)
        else $error("m_last high without m_valid");

    slverr_in_access: assert property (@(posedge aclk) disable iff (!rst_n)
        pslverr |-> psel && penable)
        else $error("pslverr high outside an access phase");

    valid_after_reset: assert property (@(posedge aclk) !rst_n |=> !m_valid)
        else $error("m_valid high in the cycle after reset");

endmodule

bind conv_engine_top conv_engine_chk chk_i (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pslverr (pslverr),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_last  (m_last),
    .m_ready (m_ready)
);

`default_nettype wire

// File: tests/conv_engine_tb.sv
`default_nettype none

module conv_engine_tb;

    localparam logic [31:0] SEED = 32'h2c771608;
    localparam int N_TESTS     = 6;
    localparam int N_PIXELS    = 16 + 24 + 18 + 6 + 40;
    localparam int CYCLE_LIMIT = N_PIXELS * 4 + N_TESTS * 200;
    localparam conv_pkg::acc_t PIX_MAX = conv_pkg::acc_t'(32767);
    localparam conv_pkg::acc_t PIX_MIN = conv_pkg::acc_t'(-32768);

    logic                 aclk;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [3:0]           paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 s_valid;
    conv_pkg::pixel_t     s_data;
    logic                 s_ready;
    logic                 m_valid;
    conv_pkg::pixel_t     m_data;
    logic                 m_last;
    logic                 m_ready;

    int                   errors;
    int                   rx_count;
    int                   cycles;
    logic [31:0]          stim_rng;
    logic [31:0]          ready_rng;
    logic                 bp_on;  // random m_ready when set
    string                cur_test;
    conv_pkg::pixel_t     stim_px [$];
    conv_pkg::pixel_t     exp_data [$];
    logic                 exp_last [$];

    conv_engine_top #(.FIFO_DEPTH(4)) dut_i (.*);

    always #5 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic conv_pkg::conv_cfg_u make_ctrl(input logic relu, input logic max_mode,
                                                      input logic [1:0] kw1,
                                                      input logic [9:0] cols_1);
        conv_pkg::conv_cfg_u u;
        u.raw = '0;
        u.f.is_relu = relu;
        u.f.is_max = max_mode;
        u.f.kernel_w_1 = kw1;
        u.f.cols_1 = cols_1;
        return u;
    endfunction

    // one result per full window inside each row of stim_px
    function automatic void build_expected(input conv_pkg::conv_cfg_u cfg,
                                           input conv_pkg::pixel_t w0,
                                           input conv_pkg::pixel_t w1,
                                           input conv_pkg::pixel_t w2);
        int row_len;
        int kw1;
        int base;
        conv_pkg::pixel_t wt [3];
        conv_pkg::pixel_t tap;
        conv_pkg::pixel_t best;
        conv_pkg::acc_t acc;
        conv_pkg::pixel_t res;
        row_len = int'(cfg.f.cols_1) + 1;
        kw1 = int'(cfg.f.kernel_w_1);
        wt[0] = w0;
        wt[1] = w1;
        wt[2] = w2;
        for (int r = 0; r < stim_px.size() / row_len; r++) begin
            base = r * row_len;
            for (int c = kw1; c < row_len; c++) begin
                best = stim_px[base + c - kw1];
                acc = '0;
                for (int k = 0; k <= kw1; k++) begin
                    tap = stim_px[base + c - kw1 + k];
                    if (tap > best) begin
                        best = tap;
                    end
                    acc = acc + conv_pkg::acc_t'(tap) * conv_pkg::acc_t'(wt[k]);
                end
                if (cfg.f.is_max) begin
                    acc = conv_pkg::acc_t'(best);
                end
                if (acc > PIX_MAX) begin
                    res = conv_pkg::pixel_t'(PIX_MAX);
                end else if (acc < PIX_MIN) begin
                    res = conv_pkg::pixel_t'(PIX_MIN);
                end else begin
                    res = conv_pkg::pixel_t'(acc);
                end
                if (cfg.f.is_relu && res[conv_pkg::DATA_WIDTH-1]) begin
                    res = '0;
                end
                exp_data.push_back(res);
                exp_last.push_back(c == row_len - 1);
            end
        end
    endfunction

    task automatic check_pixel(input string what, input conv_pkg::pixel_t exp,
                               input conv_pkg::pixel_t act);
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        psel <= 1'b1;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge aclk);
        penable <= 1'b1;
        @(posedge aclk);
        err = pslverr;
        check_bit("write pready", 1'b1, pready);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        psel <= 1'b1;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge aclk);
        penable <= 1'b1;
        @(posedge aclk);
        data = prdata;  // access phase still on the bus here
        err = pslverr;
        check_bit("read pready", 1'b1, pready);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic send_pixels(input logic gaps);
        for (int i = 0; i < stim_px.size(); i++) begin
            if (gaps) begin
                stim_rng = xorshift32(stim_rng);
                while (stim_rng[1:0] == 2'd0) begin
                    s_valid <= 1'b0;
                    @(posedge aclk);
                    stim_rng = xorshift32(stim_rng);
                end
            end
            s_valid <= 1'b1;
            s_data <= stim_px[i];
            @(posedge aclk);
            while (!s_ready) begin
                @(posedge aclk);
            end
        end
        s_valid <= 1'b0;
    endtask

    task automatic run_stream(input conv_pkg::conv_cfg_u cfg, input conv_pkg::pixel_t w0,
                              input conv_pkg::pixel_t w1, input conv_pkg::pixel_t w2,
                              input logic gaps);
        logic err;
        int n_exp;
        n_exp = stim_px.size() / (int'(cfg.f.cols_1) + 1)
              * (int'(cfg.f.cols_1) + 1 - int'(cfg.f.kernel_w_1));
        apb_write(conv_pkg::ADDR_CTRL, cfg.raw, err);
        apb_write(conv_pkg::ADDR_W0, 32'(w0), err);
        apb_write(conv_pkg::ADDR_W1, 32'(w1), err);
        apb_write(conv_pkg::ADDR_W2, 32'(w2), err);
        build_expected(cfg, w0, w1, w2);
        rx_count = 0;
        send_pixels(gaps);
        while (exp_data.size() != 0) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);  // extra results would show up here
        if (rx_count != n_exp) begin
            errors++;
            $display("mismatch %s result count: expected %0d, actual %0d",
                     cur_test, n_exp, rx_count);
        end
    endtask

    task automatic register_access();
        conv_pkg::conv_cfg_u ctrl;
        logic [31:0] rd;
        logic err;
        cur_test = "registers";
        ctrl = make_ctrl(1'b1, 1'b0, 2'd2, 10'd7);
        ctrl.raw[31:24] = 8'ha5;  // reserved bits are kept
        apb_write(conv_pkg::ADDR_CTRL, ctrl.raw, err);
        check_bit("ctrl write pslverr", 1'b0, err);
        apb_write(conv_pkg::ADDR_W0, 32'h0000_8001, err);
        apb_write(conv_pkg::ADDR_W1, 32'h1234_7ffe, err);
        apb_write(conv_pkg::ADDR_W2, 32'h0000_fffd, err);
        apb_read(conv_pkg::ADDR_CTRL, rd, err);
        check_word("ctrl", ctrl.raw, rd);
        check_bit("ctrl read pslverr", 1'b0, err);
        apb_read(conv_pkg::ADDR_W0, rd, err);
        check_word("w0", 32'hffff_8001, rd);
        apb_read(conv_pkg::ADDR_W1, rd, err);
        check_word("w1", 32'h0000_7ffe, rd);
        apb_read(conv_pkg::ADDR_W2, rd, err);
        check_word("w2", 32'hffff_fffd, rd);
        apb_write(4'hd, 32'hffff_ffff, err);
        check_bit("unmapped write pslverr", 1'b1, err);
        apb_read(4'he, rd, err);
        check_word("unmapped read", 32'h0, rd);
        check_bit("unmapped read pslverr", 1'b1, err);
        apb_read(conv_pkg::ADDR_CTRL, rd, err);
        check_word("ctrl after unmapped write", ctrl.raw, rd);
        apb_read(conv_pkg::ADDR_W2, rd, err);
        check_word("w2 after unmapped write", 32'hffff_fffd, rd);
    endtask

    task automatic three_tap_conv();
        cur_test = "three_tap";
        stim_px.delete();
        for (int i = 0; i < 16; i++) begin
            stim_px.push_back(conv_pkg::pixel_t'(i * 7 - 40));
        end
        run_stream(make_ctrl(1'b0, 1'b0, 2'd2, 10'd7), 16'sd1, -16'sd2, 16'sd3, 1'b0);
    endtask

    task automatic narrow_kernel_relu();
        cur_test = "narrow_relu";
        stim_px.delete();
        for (int i = 0; i < 12; i++) begin
            stim_px.push_back(conv_pkg::pixel_t'((i % 5) * 9 - 17));
        end
        run_stream(make_ctrl(1'b1, 1'b0, 2'd0, 10'd5), -16'sd3, 16'sd5, 16'sd7, 1'b0);
        stim_px.delete();
        for (int i = 0; i < 12; i++) begin
            stim_px.push_back(conv_pkg::pixel_t'(i * 11 - 60));
        end
        run_stream(make_ctrl(1'b1, 1'b0, 2'd1, 10'd5), 16'sd2, -16'sd3, 16'sd9, 1'b0);
    endtask

    task automatic max_mode();
        cur_test = "max";
        stim_px.delete();
        for (int i = 0; i < 12; i++) begin
            stim_px.push_back(conv_pkg::pixel_t'((i * 37) % 61 - 30));
        end
        run_stream(make_ctrl(1'b0, 1'b1, 2'd2, 10'd5), 16'sd32767, -16'sd1, 16'sd5, 1'b0);
        stim_px.delete();
        for (int i = 0; i < 6; i++) begin
            stim_px.push_back(conv_pkg::pixel_t'(-100 - i * 13));  // a zeroed tap must lose
        end
        run_stream(make_ctrl(1'b0, 1'b1, 2'd1, 10'd5), 16'sd4, 16'sd4, 16'sd4, 1'b0);
    endtask

    task automatic saturation_clamp();
        cur_test = "saturation";
        stim_px.delete();
        for (int i = 0; i < 6; i++) begin
            stim_px.push_back((i < 3) ? 16'sh7fff : 16'sh8000);
        end
        run_stream(make_ctrl(1'b0, 1'b0, 2'd2, 10'd5), 16'sh7fff, 16'sh7fff, 16'sh7fff, 1'b0);
    endtask

    task automatic backpressure_stream();
        conv_pkg::pixel_t wt [3];
        cur_test = "backpressure";
        stim_px.delete();
        for (int k = 0; k < 3; k++) begin
            stim_rng = xorshift32(stim_rng);
            wt[k] = conv_pkg::pixel_t'(int'(stim_rng[3:0]) - 8);
        end
        for (int i = 0; i < 40; i++) begin
            stim_rng = xorshift32(stim_rng);
            stim_px.push_back(conv_pkg::pixel_t'(int'(stim_rng[12:0]) - 4096));
        end
        bp_on <= 1'b1;
        run_stream(make_ctrl(1'b0, 1'b0, 2'd2, 10'd9), wt[0], wt[1], wt[2], 1'b1);
        bp_on <= 1'b0;
    endtask

    always @(posedge aclk) begin
        ready_rng = xorshift32(ready_rng);
        if (bp_on) begin
            m_ready <= (ready_rng[1:0] != 2'd0);
        end else begin
            m_ready <= 1'b1;
        end
    end

    // pops one expected entry per output transfer
    always @(posedge aclk) begin
        if (rst_n && m_valid && m_ready) begin
            rx_count++;
            if (exp_data.size() == 0) begin
                errors++;
                $display("%s: result %0d came out with nothing expected", cur_test, m_data);
            end else begin
                check_pixel("m_data", exp_data.pop_front(), m_data);
                check_bit("m_last", exp_last.pop_front(), m_last);
            end
        end
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d expected results never came out",
                     cycles, exp_data.size());
            $display("run stopped with %0d errors", errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        aclk = 1'b0;
        rst_n <= 1'b0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        s_valid <= 1'b0;
        s_data <= '0;
        m_ready <= 1'b1;
        bp_on <= 1'b0;
        errors = 0;
        rx_count = 0;
        cycles = 0;
        stim_rng = SEED;
        ready_rng = ~SEED;
        cur_test = "reset";
        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;
        register_access();
        three_tap_conv();
        narrow_kernel_relu();
        max_mode();
        saturation_clamp();
        backpressure_stream();
        if (exp_data.size() != 0) begin
            errors++;
            $display("%0d expected results were left over at the end", exp_data.size());
        end
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/conv_cfg_apb.sv
`default_nettype none

module conv_cfg_apb (
    input  wire logic                                          aclk,
    input  wire logic                                          rst_n,
    input  wire logic                                          psel,
    input  wire logic                                          penable,
    input  wire logic                                          pwrite,
    input  wire logic [conv_pkg::APB_AW-1:0]                   paddr,
    input  wire logic [conv_pkg::APB_DW-1:0]                   pwdata,
    output logic [conv_pkg::APB_DW-1:0]                        prdata,
    output logic                                               pready,
    output logic                                               pslverr,
    output conv_pkg::conv_cfg_u                                cfg,
    output conv_pkg::pixel_t [conv_pkg::KERNEL_W_MAX-1:0]      weights
);

    logic access;

    assign access  = psel && penable;
    assign pready  = 1'b1;  // zero wait states
    assign pslverr = access && (paddr > conv_pkg::ADDR_W2);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            cfg.raw <= '0;
            weights <= '0;
        end else if (access && pwrite) begin
            case (paddr)
                conv_pkg::ADDR_CTRL: cfg.raw    <= pwdata;
                conv_pkg::ADDR_W0:   weights[0] <= pwdata[conv_pkg::DATA_WIDTH-1:0];
                conv_pkg::ADDR_W1:   weights[1] <= pwdata[conv_pkg::DATA_WIDTH-1:0];
                conv_pkg::ADDR_W2:   weights[2] <= pwdata[conv_pkg::DATA_WIDTH-1:0];
                default: ;  // unmapped, dropped
            endcase
        end
    end

    // readback, weights sign-extended to the bus width
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                conv_pkg::ADDR_CTRL: prdata = cfg.raw;
                conv_pkg::ADDR_W0:   prdata = conv_pkg::APB_DW'(weights[0]);
                conv_pkg::ADDR_W1:   prdata = conv_pkg::APB_DW'(weights[1]);
                conv_pkg::ADDR_W2:   prdata = conv_pkg::APB_DW'(weights[2]);
                default:             prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/conv_engine_top.sv
`default_nettype none

module conv_engine_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                           aclk,
    input  wire logic                           rst_n,

    input  wire logic                           psel,
    input  wire logic                           penable,
    input  wire logic                           pwrite,
    input  wire logic [conv_pkg::APB_AW-1:0]    paddr,
    input  wire logic [conv_pkg::APB_DW-1:0]    pwdata,
    output logic [conv_pkg::APB_DW-1:0]         prdata,
    output logic                                pready,
    output logic                                pslverr,

    input  wire logic                           s_valid,
    input  wire conv_pkg::pixel_t               s_data,
    output logic                                s_ready,

    output logic                                m_valid,
    output conv_pkg::pixel_t                    m_data,
    output logic                                m_last,
    input  wire logic                           m_ready
);

    conv_pkg::conv_cfg_u                                cfg;
    conv_pkg::pixel_t [conv_pkg::KERNEL_W_MAX-1:0]      weights;

    conv_window_if win_in ();
    conv_window_if win_out ();

    conv_cfg_apb cfg_i (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg),
        .weights (weights)
    );

    conv_window window_i (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_data  (s_data),
        .cfg     (cfg),
        .s_ready (s_ready),
        .win     (win_in.producer)
    );

    conv_window_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .aclk  (aclk),
        .rst_n (rst_n),
        .wr    (win_in.consumer),
        .rd    (win_out.producer)
    );

    conv_mac mac_i (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .weights (weights),
        .m_ready (m_ready),
        .win     (win_out.consumer),
        .m_valid (m_valid),
        .m_data  (m_data),
        .m_last  (m_last)
    );

endmodule

`default_nettype wire

// File: verilog/conv_mac.sv
`default_nettype none

module conv_mac (
    input  wire logic                                         aclk,
    input  wire logic                                         rst_n,
    input  wire conv_pkg::conv_cfg_u                          cfg,
    input  wire conv_pkg::pixel_t [conv_pkg::KERNEL_W_MAX-1:0] weights,
    input  wire logic                                         m_ready,
    conv_window_if.consumer                                   win,
    output logic                                              m_valid,
    output conv_pkg::pixel_t                                  m_data,
    output logic                                              m_last
);

    localparam int KW = conv_pkg::KERNEL_W_MAX;
    localparam conv_pkg::acc_t SAT_HI =
        conv_pkg::acc_t'((1 << (conv_pkg::DATA_WIDTH - 1)) - 1);
    localparam conv_pkg::acc_t SAT_LO = -SAT_HI - 1;

    logic               stall;
    conv_pkg::pixel_t   tap_max;
    conv_pkg::acc_t     prod   [KW];
    conv_pkg::acc_t     s1_prod [KW];
    logic               s1_valid;
    logic               s1_last;
    conv_pkg::acc_t     sum;
    conv_pkg::pixel_t   sat;
    conv_pkg::pixel_t   result;

    assign stall     = m_valid && !m_ready;  // whole pipe freezes
    assign win.ready = !stall;

    // stage one: products, or the max placed in slot 0
    always_comb begin
        tap_max = win.taps[0];
        for (int i = 1; i < KW; i++) begin
            if (i <= int'(cfg.f.kernel_w_1) && win.taps[i] > tap_max) begin
                tap_max = win.taps[i];
            end
        end
        for (int i = 0; i < KW; i++) begin
            if (cfg.f.is_max) begin
                prod[i] = (i == 0) ? conv_pkg::acc_t'(tap_max) : '0;
            end else begin
                prod[i] = conv_pkg::acc_t'(win.taps[i]) * conv_pkg::acc_t'(weights[i]);
            end
        end
    end

    // stage two: sum, clamp, relu
    always_comb begin
        sum = '0;
        for (int i = 0; i < KW; i++) begin
            sum = sum + s1_prod[i];
        end
        if (sum > SAT_HI) begin
            sat = conv_pkg::pixel_t'(SAT_HI);
        end else if (sum < SAT_LO) begin
            sat = conv_pkg::pixel_t'(SAT_LO);
        end else begin
            sat = conv_pkg::pixel_t'(sum);
        end
        result = (cfg.f.is_relu && sat < 0) ? '0 : sat;
    end

    always_ff @(posedge aclk) begin
        if (!stall) begin
            s1_prod <= prod;
            m_data  <= result;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            m_valid  <= 1'b0;
            m_last   <= 1'b0;
        end else if (!stall) begin
            s1_valid <= win.valid;
            s1_last  <= win.valid && win.last;  // never high on a bubble
            m_valid  <= s1_valid;
            m_last   <= s1_last;
        end
    end

endmodule

`default_nettype wire

// File: verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int DATA_WIDTH   = 16;
    localparam int KERNEL_W_MAX = 3;
    localparam int COLS_WIDTH   = 10;
    localparam int ACC_WIDTH    = 34;  // three full-scale products fit
    localparam int APB_AW       = 4;
    localparam int APB_DW       = 32;

    typedef logic signed [DATA_WIDTH-1:0] pixel_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    // control register layout, bit 0 first from the bottom
    typedef struct packed {
        logic [APB_DW-COLS_WIDTH-5:0] reserved;
        logic [COLS_WIDTH-1:0]        cols_1;
        logic [1:0]                   kernel_w_1;
        logic                         is_max;
        logic                         is_relu;
    } conv_cfg_t;

    typedef union packed {
        logic [APB_DW-1:0] raw;  // bus view
        conv_cfg_t         f;    // datapath view
    } conv_cfg_u;

    localparam logic [APB_AW-1:0] ADDR_CTRL = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_W0   = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_W1   = 4'h8;
    localparam logic [APB_AW-1:0] ADDR_W2   = 4'hC;

endpackage

`default_nettype wire

// File: verilog/conv_window.sv
`default_nettype none

module conv_window (
    input  wire logic                aclk,
    input  wire logic                rst_n,
    input  wire logic                s_valid,
    input  wire conv_pkg::pixel_t    s_data,
    input  wire conv_pkg::conv_cfg_u cfg,
    output logic                     s_ready,
    conv_window_if.producer          win
);

    localparam int KW = conv_pkg::KERNEL_W_MAX;

    conv_pkg::pixel_t [KW-1:0]          shreg;  // newest at top index
    logic [conv_pkg::COLS_WIDTH-1:0]    col;
    logic [1:0]                         kw1;
    logic                               accept;
    logic                               win_valid;
    logic                               win_last;

    assign kw1 = (cfg.f.kernel_w_1 > 2'(KW - 1)) ? 2'(KW - 1) : cfg.f.kernel_w_1;

    // stall only while a finished window is still waiting
    assign s_ready   = !(win_valid && !win.ready);
    assign accept    = s_valid && s_ready;
    assign win.valid = win_valid;
    assign win.last  = win_last;

    always_ff @(posedge aclk) begin
        if (accept) begin
            shreg <= {s_data, shreg[KW-1:1]};
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            col       <= '0;
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            if (win_valid && win.ready) begin
                win_valid <= 1'b0;
            end
            if (accept) begin
                if (col >= conv_pkg::COLS_WIDTH'(kw1)) begin
                    win_valid <= 1'b1;
                    win_last  <= (col == cfg.f.cols_1);
                end
                col <= (col == cfg.f.cols_1) ? '0 : col + 1'b1;  // next row
            end
        end
    end

    // align the newest kw1+1 pixels to tap 0 upward, zero the rest
    always_comb begin
        for (int i = 0; i < KW; i++) begin
            if (i <= int'(kw1)) begin
                win.taps[i] = shreg[i + KW - 1 - int'(kw1)];
            end else begin
                win.taps[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/conv_window_fifo.sv
`default_nettype none

module conv_window_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic        aclk,
    input  wire logic        rst_n,
    conv_window_if.consumer  wr,
    conv_window_if.producer  rd
);

    localparam int KW = conv_pkg::KERNEL_W_MAX;
    localparam int AW = $clog2(FIFO_DEPTH);

    conv_pkg::pixel_t [KW-1:0]  mem_taps [FIFO_DEPTH];
    logic                       mem_last [FIFO_DEPTH];
    logic [AW:0]                wr_ptr;  // msb is the wrap bit
    logic [AW:0]                rd_ptr;
    logic                       full;
    logic                       empty;
    logic                       push;
    logic                       pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign push  = wr.valid && wr.ready;
    assign pop   = rd.valid && rd.ready;

    assign wr.ready = !full;
    assign rd.valid = !empty;
    assign rd.taps  = mem_taps[rd_ptr[AW-1:0]];
    assign rd.last  = mem_last[rd_ptr[AW-1:0]];

    always_ff @(posedge aclk) begin
        if (push) begin
            mem_taps[wr_ptr[AW-1:0]] <= wr.taps;
            mem_last[wr_ptr[AW-1:0]] <= wr.last;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/conv_window_if.sv
`default_nettype none

interface conv_window_if;

    logic                                             valid;
    logic                                             ready;
    conv_pkg::pixel_t [conv_pkg::KERNEL_W_MAX-1:0]    taps;  // tap 0 oldest
    logic                                             last;  // final window of a row

    modport producer (
        output valid,
        output taps,
        output last,
        input  ready
    );

    modport consumer (
        input  valid,
        input  taps,
        input  last,
        output ready
    );

endinterface

`default_nettype wire
